//--- geom_if.sv
interface geom_if;

    image_read_pkg::coord_t pad_l;     // left padding
    image_read_pkg::coord_t pad_t;     // top padding
    image_read_pkg::coord_t edge_l;    // first image column in the padded area
    image_read_pkg::coord_t edge_r;    // last image column
    image_read_pkg::coord_t edge_t;
    image_read_pkg::coord_t edge_b;
    image_read_pkg::coord_t img_d;     // depth, one based
    image_read_pkg::coord_t plane_wxd; // addresses per image row

    modport ctrl (
        output pad_l, pad_t, edge_l, edge_r, edge_t, edge_b, img_d, plane_wxd
    );

    modport addr (
        input pad_l, pad_t, edge_l, edge_r, edge_t, edge_b, img_d, plane_wxd
    );

endinterface

//--- image_read.sv
module image_read (
    input  logic                                  clk,
    input  logic                                  rst,

    input  logic [image_read_pkg::CFG_DWIDTH-1:0] cfg_data_i,
    input  logic [image_read_pkg::CFG_AWIDTH-1:0] cfg_addr_i,
    input  logic                                  cfg_valid_i,

    input  logic                                  next_i,
    output logic                                  next_rdy_o,

    output logic                                  rd_val_o,
    output image_read_pkg::mem_addr_t             rd_addr_o,
    input  image_read_pkg::pixel_bus_t            rd_data_i,

    output image_read_pkg::pixel_bus_t            image_bus_o,
    output logic                                  image_last_o,
    output logic                                  image_val_o,
    input  logic                                  image_rdy_i
);

    geom_if geom ();

    image_read_pkg::coord_t [image_read_pkg::STAGE_NB-1:0] limit;
    image_read_pkg::coord_t [image_read_pkg::STAGE_NB-1:0] step;
    image_read_pkg::coord_t [image_read_pkg::STAGE_NB-1:0] count;

    logic [image_read_pkg::STAGE_NB:0]   carry; // carry[0] is the scan step
    logic [image_read_pkg::STAGE_NB-1:0] done;

    logic                       scan_start;
    logic                       push;
    image_read_pkg::pixel_bus_t push_data;
    logic                       push_last;

    assign scan_start = next_i & next_rdy_o; // counters restart with every scan

    image_read_ctrl i_ctrl (
        .clk         (clk),
        .rst         (rst),
        .cfg_data_i  (cfg_data_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_valid_i (cfg_valid_i),
        .next_i      (next_i),
        .next_rdy_o  (next_rdy_o),
        .image_rdy_i (image_rdy_i),
        .done_i      (&done),
        .scan_step_o (carry[0]),
        .limit_o     (limit),
        .step_o      (step),
        .geom        (geom.ctrl)
    );

    for (genvar g = 0; g < image_read_pkg::STAGE_NB; g++) begin : g_stage
        window_counter i_counter (
            .clk     (clk),
            .rst     (rst),
            .clear_i (scan_start),
            .carry_i (carry[g]),
            .limit_i (limit[g]),
            .step_i  (step[g]),
            .count_o (count[g]),
            .carry_o (carry[g+1]),
            .done_o  (done[g])
        );
    end

    image_read_addr i_addr (
        .clk         (clk),
        .rst         (rst),
        .pos_val_i   (carry[0]),
        .pos_last_i  (carry[image_read_pkg::STAGE_NB]), // every stage wraps
        .count_i     (count),
        .geom        (geom.addr),
        .rd_val_o    (rd_val_o),
        .rd_addr_o   (rd_addr_o),
        .rd_data_i   (rd_data_i),
        .push_o      (push),
        .push_data_o (push_data),
        .push_last_o (push_last)
    );

    image_read_buffer i_buffer (
        .clk          (clk),
        .rst          (rst),
        .push_i       (push),
        .push_data_i  (push_data),
        .push_last_i  (push_last),
        .image_bus_o  (image_bus_o),
        .image_last_o (image_last_o),
        .image_val_o  (image_val_o),
        .image_rdy_i  (image_rdy_i)
    );

endmodule

//--- image_read_addr.sv
module image_read_addr (
    input  logic                                                  clk,
    input  logic                                                  rst,

    input  logic                                                  pos_val_i,
    input  logic                                                  pos_last_i,
    input  image_read_pkg::coord_t [image_read_pkg::STAGE_NB-1:0] count_i,

    geom_if.addr                                                  geom,

    output logic                                                  rd_val_o,
    output image_read_pkg::mem_addr_t                             rd_addr_o,
    input  image_read_pkg::pixel_bus_t                            rd_data_i,

    output logic                                                  push_o,
    output image_read_pkg::pixel_bus_t                            push_data_o,
    output logic                                                  push_last_o
);

    image_read_pkg::coord_t    row_1p;  // position in the padded area
    image_read_pkg::coord_t    col_1p;
    image_read_pkg::coord_t    dep_1p;
    image_read_pkg::coord_t    row_2p;
    image_read_pkg::coord_t    col_2p;
    image_read_pkg::coord_t    dep_2p;
    image_read_pkg::coord_t    sum_3p;
    image_read_pkg::coord_t    dep_3p;
    image_read_pkg::mem_addr_t addr_4p;

    logic [1:0] val_q;   // 1p, 2p
    logic       pad_2p;
    logic [1:0] pad_q;   // 3p, 4p
    logic [1:0] rd_q;    // read beats at 3p, 4p
    logic [3:0] last_q;  // 1p to 4p

    // flags waiting for the memory
    logic [image_read_pkg::RD_LATENCY-1:0] rd_line;
    logic [image_read_pkg::RD_LATENCY-1:0] pad_line;
    logic [image_read_pkg::RD_LATENCY-1:0] last_line;

    always_ff @(posedge clk) begin
        row_1p <= count_i[image_read_pkg::ST_AREA_H] + count_i[image_read_pkg::ST_ROW];
        col_1p <= count_i[image_read_pkg::ST_AREA_W] + count_i[image_read_pkg::ST_COL];
        dep_1p <= count_i[image_read_pkg::ST_DEPTH];

        row_2p <= (row_1p - geom.pad_t) * geom.plane_wxd;
        col_2p <= (col_1p - geom.pad_l) * geom.img_d;
        dep_2p <= dep_1p;

        sum_3p <= row_2p + col_2p;
        dep_3p <= dep_2p;

        addr_4p <= sum_3p + dep_3p;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            val_q     <= '0;
            pad_2p    <= 1'b0;
            pad_q     <= '0;
            rd_q      <= '0;
            last_q    <= '0;
            rd_line   <= '0;
            pad_line  <= '0;
            last_line <= '0;
        end else begin
            val_q  <= {val_q[0], pos_val_i};
            last_q <= {last_q[2:0], pos_val_i & pos_last_i};

            // outside the image edges means a padding beat
            pad_2p <= val_q[0] & ((col_1p < geom.edge_l) | (col_1p > geom.edge_r)
                                | (row_1p < geom.edge_t) | (row_1p > geom.edge_b));

            pad_q <= {pad_q[0], pad_2p};
            rd_q  <= {rd_q[0], val_q[1] & ~pad_2p};

            rd_line   <= {rd_line[image_read_pkg::RD_LATENCY-2:0], rd_q[1]};
            pad_line  <= {pad_line[image_read_pkg::RD_LATENCY-2:0], pad_q[1]};
            last_line <= {last_line[image_read_pkg::RD_LATENCY-2:0], last_q[3]};
        end
    end

    assign rd_val_o  = rd_q[1];
    assign rd_addr_o = addr_4p;

    always_ff @(posedge clk) begin
        if (rst) begin
            push_o      <= 1'b0;
            push_last_o <= 1'b0;
        end else begin
            push_o      <= rd_line[image_read_pkg::RD_LATENCY-1]
                         | pad_line[image_read_pkg::RD_LATENCY-1];
            push_last_o <= last_line[image_read_pkg::RD_LATENCY-1];
        end
    end

    // padding beats carry zero
    always_ff @(posedge clk) begin
        if (rd_line[image_read_pkg::RD_LATENCY-1]) begin
            push_data_o <= rd_data_i;
        end else begin
            push_data_o <= '0;
        end
    end

endmodule

//--- image_read_buffer.sv
module image_read_buffer (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       push_i,
    input  image_read_pkg::pixel_bus_t push_data_i,
    input  logic                       push_last_i,

    output image_read_pkg::pixel_bus_t image_bus_o,
    output logic                       image_last_o,
    output logic                       image_val_o,
    input  logic                       image_rdy_i
);

    image_read_pkg::pixel_bus_t mem_data [2**image_read_pkg::BUF_AWIDTH];
    logic                       mem_last [2**image_read_pkg::BUF_AWIDTH];

    // extra msb tells full from empty
    logic [image_read_pkg::BUF_AWIDTH:0] wr_ptr;
    logic [image_read_pkg::BUF_AWIDTH:0] rd_ptr;

    logic empty;
    logic pop;
    logic last_q;

    assign empty = (wr_ptr == rd_ptr);
    assign pop   = ~empty & (~image_val_o | image_rdy_i); // output free or taken

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem_data[wr_ptr[image_read_pkg::BUF_AWIDTH-1:0]] <= push_data_i;
            mem_last[wr_ptr[image_read_pkg::BUF_AWIDTH-1:0]] <= push_last_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) wr_ptr <= wr_ptr + 1'b1;
            if (pop)    rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            image_val_o <= 1'b0;
        end else if (~image_val_o | image_rdy_i) begin
            image_val_o <= ~empty;
        end
    end

    // bus holds while stalled
    always_ff @(posedge clk) begin
        if (pop) begin
            image_bus_o <= mem_data[rd_ptr[image_read_pkg::BUF_AWIDTH-1:0]];
            last_q      <= mem_last[rd_ptr[image_read_pkg::BUF_AWIDTH-1:0]];
        end
    end

    assign image_last_o = image_val_o & last_q;

endmodule

//--- image_read_chk.sv
module image_read_chk (
    input logic                       clk,
    input logic                       rst,
    input logic                       push_i,
    input image_read_pkg::pixel_bus_t image_bus_i,
    input logic                       image_last_i,
    input logic                       image_val_i,
    input logic                       image_rdy_i,
    input logic                       next_i,
    input logic                       next_rdy_i
);

    int fill; // beats held in the FIFO and the output register

    always_ff @(posedge clk) begin
        if (rst) begin
            fill <= 0;
        end else begin
            fill <= fill + int'(push_i) - int'(image_val_i && image_rdy_i);
        end
    end

    // a stalled beat stays on the bus unchanged
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        (image_val_i && !image_rdy_i) |=>
            (image_val_i && $stable(image_bus_i) && $stable(image_last_i)))
        else $error("image bus or last flag changed while stalled");

    // sixteen FIFO entries plus the output register
    no_overflow: assert property (@(posedge clk) disable iff (rst)
        fill <= 2**image_read_pkg::BUF_AWIDTH + 1)
        else $error("more beats in flight than the buffer can hold");

    next_rdy_hold: assert property (@(posedge clk) disable iff (rst)
        (next_rdy_i && !next_i) |=> next_rdy_i) // only a taken next lowers it
        else $error("next ready fell without an accepted next");

endmodule

//--- image_read_ctrl.sv
module image_read_ctrl (
    input  logic                                                   clk,
    input  logic                                                   rst,

    input  logic [image_read_pkg::CFG_DWIDTH-1:0]                  cfg_data_i,
    input  logic [image_read_pkg::CFG_AWIDTH-1:0]                  cfg_addr_i,
    input  logic                                                   cfg_valid_i,

    input  logic                                                   next_i,
    output logic                                                   next_rdy_o,

    input  logic                                                   image_rdy_i,
    input  logic                                                   done_i,

    output logic                                                   scan_step_o,
    output image_read_pkg::coord_t [image_read_pkg::STAGE_NB-1:0]  limit_o,
    output image_read_pkg::coord_t [image_read_pkg::STAGE_NB-1:0]  step_o,

    geom_if.ctrl                                                   geom
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SETUP,
        S_ACTIVE,
        S_PAUSE
    } state_t;

    state_t state;
    state_t state_nx;

    // shadow registers, written at any time from the cfg bus
    image_read_pkg::coord_t cfg_img_w;
    image_read_pkg::coord_t cfg_img_h;
    image_read_pkg::coord_t cfg_img_d;
    logic [7:0]             cfg_pad_l;
    logic [7:0]             cfg_pad_r;
    logic [7:0]             cfg_pad_t;
    logic [7:0]             cfg_pad_b;
    logic [7:0]             cfg_conv_side;
    image_read_pkg::coord_t cfg_conv_step;

    // working copies, one based, loaded on an accepted next
    image_read_pkg::coord_t img_w;
    image_read_pkg::coord_t img_h;
    image_read_pkg::coord_t img_d;
    image_read_pkg::coord_t pad_l;
    image_read_pkg::coord_t pad_r;
    image_read_pkg::coord_t pad_t;
    image_read_pkg::coord_t pad_b;
    image_read_pkg::coord_t conv_side;
    image_read_pkg::coord_t conv_step;

    image_read_pkg::coord_t area_w; // image plus padding
    image_read_pkg::coord_t area_h;

    logic accept;
    logic next_1p;
    logic next_2p;
    logic next_3p;

    assign accept = next_i & next_rdy_o;

    always_ff @(posedge clk) begin
        if (cfg_valid_i) begin
            case (cfg_addr_i)
                image_read_pkg::CFG_IMG_W: cfg_img_w <= cfg_data_i[15:0];
                image_read_pkg::CFG_IMG_DH: begin
                    cfg_img_d <= cfg_data_i[31:16];
                    cfg_img_h <= cfg_data_i[15:0];
                end
                image_read_pkg::CFG_PAD: begin
                    cfg_pad_l <= cfg_data_i[31:24];
                    cfg_pad_r <= cfg_data_i[23:16];
                    cfg_pad_t <= cfg_data_i[15:8];
                    cfg_pad_b <= cfg_data_i[7:0];
                end
                image_read_pkg::CFG_CONV: begin
                    cfg_conv_side <= cfg_data_i[23:16];
                    cfg_conv_step <= cfg_data_i[15:0];
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            next_rdy_o <= 1'b0;
        end else if (accept) begin
            next_rdy_o <= 1'b0;
        end else if (state == S_IDLE) begin
            next_rdy_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            next_1p <= 1'b0;
            next_2p <= 1'b0;
            next_3p <= 1'b0;
        end else begin
            next_1p <= accept;
            next_2p <= next_1p;
            next_3p <= next_2p;
        end
    end

    // step 1: zero based fields become counts
    always_ff @(posedge clk) begin
        if (accept) begin
            img_w     <= cfg_img_w + 16'd1;
            img_h     <= cfg_img_h + 16'd1;
            img_d     <= cfg_img_d + 16'd1;
            pad_l     <= {8'd0, cfg_pad_l};
            pad_r     <= {8'd0, cfg_pad_r};
            pad_t     <= {8'd0, cfg_pad_t};
            pad_b     <= {8'd0, cfg_pad_b};
            conv_side <= {8'd0, cfg_conv_side} + 16'd1;
            conv_step <= cfg_conv_step + 16'd1;
        end
    end

    // step 2: padded area, image edges and row pitch
    always_ff @(posedge clk) begin
        area_w         <= pad_l + img_w + pad_r;
        area_h         <= pad_t + img_h + pad_b;
        geom.edge_l    <= pad_l;
        geom.edge_r    <= pad_l + img_w - 16'd1;
        geom.edge_t    <= pad_t;
        geom.edge_b    <= pad_t + img_h - 16'd1;
        geom.plane_wxd <= img_w * img_d;
    end

    // step 3: last count of every stage
    always_ff @(posedge clk) begin
        limit_o[image_read_pkg::ST_DEPTH]  <= img_d - 16'd1;
        limit_o[image_read_pkg::ST_COL]    <= conv_side - 16'd1;
        limit_o[image_read_pkg::ST_ROW]    <= conv_side - 16'd1;
        limit_o[image_read_pkg::ST_AREA_W] <= area_w - conv_side; // last full window start
        limit_o[image_read_pkg::ST_AREA_H] <= area_h - conv_side;
    end

    always_comb begin
        step_o[image_read_pkg::ST_DEPTH]  = 16'd1;
        step_o[image_read_pkg::ST_COL]    = 16'd1;
        step_o[image_read_pkg::ST_ROW]    = 16'd1;
        step_o[image_read_pkg::ST_AREA_W] = conv_step;
        step_o[image_read_pkg::ST_AREA_H] = conv_step;
    end

    assign geom.pad_l = pad_l;
    assign geom.pad_t = pad_t;
    assign geom.img_d = img_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            S_IDLE: begin
                if (accept) state_nx = S_SETUP;
            end
            S_SETUP: begin
                if (next_3p) state_nx = image_rdy_i ? S_ACTIVE : S_PAUSE;
            end
            S_ACTIVE: begin
                if (done_i) begin
                    state_nx = S_IDLE; // final position advances this cycle
                end else if (!image_rdy_i) begin
                    state_nx = S_PAUSE;
                end
            end
            S_PAUSE: begin
                if (image_rdy_i) state_nx = S_ACTIVE;
            end
            default: state_nx = S_IDLE;
        endcase
    end

    assign scan_step_o = (state == S_ACTIVE);

endmodule

//--- image_read_pkg.sv
package image_read_pkg;

    // configuration bus
    localparam int CFG_DWIDTH = 32;
    localparam int CFG_AWIDTH = 2;

    localparam logic [CFG_AWIDTH-1:0] CFG_IMG_W  = 2'd0; // width-1 in 15:0
    localparam logic [CFG_AWIDTH-1:0] CFG_IMG_DH = 2'd1; // depth-1 in 31:16, height-1 in 15:0
    localparam logic [CFG_AWIDTH-1:0] CFG_PAD    = 2'd2; // left, right, top, bottom bytes
    localparam logic [CFG_AWIDTH-1:0] CFG_CONV   = 2'd3; // side-1 in 23:16, step-1 in 15:0

    // one beat is four groups of 16-bit pixels
    localparam int GROUP_NB  = 4;
    localparam int IMG_WIDTH = 16;

    typedef logic [GROUP_NB*IMG_WIDTH-1:0] pixel_bus_t;

    localparam int MEM_AWIDTH = 16;

    typedef logic [MEM_AWIDTH-1:0] mem_addr_t;
    typedef logic [15:0]           coord_t;

    // read address to read data, in cycles
    localparam int RD_LATENCY = 3;

    // counter stages, innermost first
    localparam int STAGE_NB  = 5;
    localparam int ST_DEPTH  = 0;
    localparam int ST_COL    = 1;
    localparam int ST_ROW    = 2;
    localparam int ST_AREA_W = 3;
    localparam int ST_AREA_H = 4;

    localparam int BUF_AWIDTH = 4; // 16 entries

endpackage

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for a failure in the log
set -e

verilator --binary --assert --top-module tb_image_read -f src.f -o sim_image_read
./obj_dir/sim_image_read > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
exit 0

//--- src.f
image_read_pkg.sv
geom_if.sv
image_read_ctrl.sv
window_counter.sv
image_read_addr.sv
image_read_buffer.sv
image_read.sv
tb_clk_gen.sv
image_read_chk.sv
tb_image_read.sv

//--- tb_clk_gen.sv
module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o; // period 10
    end

    // reset spans five rising edges, released just after the fifth
    initial begin
        rst_o = 1'b1;
        repeat (5) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

//--- tb_image_read.sv
module tb_image_read;

    // scan geometry in counts, one based
    typedef struct packed {
        int w;
        int h;
        int d;
        int pad_l;
        int pad_r;
        int pad_t;
        int pad_b;
        int side;
        int step;
    } scan_cfg_t;

    logic                                  clk;
    logic                                  rst;
    logic [image_read_pkg::CFG_DWIDTH-1:0] cfg_data;
    logic [image_read_pkg::CFG_AWIDTH-1:0] cfg_addr;
    logic                                  cfg_valid;
    logic                                  next;
    logic                                  next_rdy;
    logic                                  rd_val;
    image_read_pkg::mem_addr_t             rd_addr;
    image_read_pkg::pixel_bus_t            rd_data;
    image_read_pkg::pixel_bus_t            image_bus;
    logic                                  image_last;
    logic                                  image_val;
    logic                                  image_rdy;

    image_read_pkg::pixel_bus_t got_data [$];
    logic                       got_last [$];
    image_read_pkg::pixel_bus_t exp_data [$];
    logic                       exp_last [$];

    scan_cfg_t   cfg_plain;
    scan_cfg_t   cfg_pad;
    scan_cfg_t   cfg_stride;
    scan_cfg_t   cfg_b;
    int          n_tests = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          n_reads = 0;
    int          reads_base = 0;
    int          exp_reads = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    bit          random_rdy = 1'b0;
    logic [31:0] lcg_state = 32'hc3b7_d25a;

    tb_clk_gen i_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    image_read i_image_read (
        .clk          (clk),
        .rst          (rst),
        .cfg_data_i   (cfg_data),
        .cfg_addr_i   (cfg_addr),
        .cfg_valid_i  (cfg_valid),
        .next_i       (next),
        .next_rdy_o   (next_rdy),
        .rd_val_o     (rd_val),
        .rd_addr_o    (rd_addr),
        .rd_data_i    (rd_data),
        .image_bus_o  (image_bus),
        .image_last_o (image_last),
        .image_val_o  (image_val),
        .image_rdy_i  (image_rdy)
    );

    bind image_read image_read_chk i_chk (
        .clk          (clk),
        .rst          (rst),
        .push_i       (push),
        .image_bus_i  (image_bus_o),
        .image_last_i (image_last_o),
        .image_val_i  (image_val_o),
        .image_rdy_i  (image_rdy_i),
        .next_i       (next_i),
        .next_rdy_i   (next_rdy_o)
    );

    // memory answers three cycles after the address, address copied to all groups
    initial begin : mem_model
        image_read_pkg::pixel_bus_t stage_0;
        image_read_pkg::pixel_bus_t stage_1;
        stage_0 = '0;
        stage_1 = '0;
        rd_data <= '0;
        forever begin
            @(posedge clk);
            rd_data <= stage_1;
            stage_1 = stage_0;
            stage_0 = {4{rd_addr}};
        end
    end

    initial begin : rdy_driver
        logic [31:0] rnd;
        image_rdy = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            rnd = next_random();
            image_rdy = random_rdy ? rnd[16] : 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst && image_val && image_rdy) begin
            got_data.push_back(image_bus);
            got_last.push_back(image_last);
        end
    end

    always @(posedge clk) begin
        if (!rst && rd_val) begin
            n_reads <= n_reads + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // starts 0, step, 2*step ... until one reaches the limit
    function automatic int start_count(input int limit, input int step);
        if (limit <= 0) return 1;
        return (limit + step - 1) / step + 1;
    endfunction

    function automatic int beat_count(input scan_cfg_t c);
        return start_count(c.pad_l + c.w + c.pad_r - c.side, c.step)
             * start_count(c.pad_t + c.h + c.pad_b - c.side, c.step)
             * c.side * c.side * c.d;
    endfunction

    task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_cfg(input logic [image_read_pkg::CFG_AWIDTH-1:0] addr,
                             input logic [image_read_pkg::CFG_DWIDTH-1:0] data);
        cfg_valid = 1'b1;
        cfg_addr  = addr;
        cfg_data  = data;
        @(posedge clk);
        #1;
        cfg_valid = 1'b0;
    endtask

    task automatic load_config(input scan_cfg_t c);
        write_cfg(image_read_pkg::CFG_IMG_W, {16'd0, 16'(c.w - 1)});
        write_cfg(image_read_pkg::CFG_IMG_DH, {16'(c.d - 1), 16'(c.h - 1)});
        write_cfg(image_read_pkg::CFG_PAD, {8'(c.pad_l), 8'(c.pad_r), 8'(c.pad_t), 8'(c.pad_b)});
        write_cfg(image_read_pkg::CFG_CONV, {8'd0, 8'(c.side - 1), 16'(c.step - 1)});
    endtask

    task automatic start_scan();
        while (!next_rdy) begin
            @(posedge clk);
            #1;
        end
        next = 1'b1;
        @(posedge clk);
        #1;
        next = 1'b0;
    endtask

    // depth fastest, then window column, window row, start column, start row
    task automatic build_expected(input scan_cfg_t c);
        int  n_w;
        int  n_h;
        int  row;
        int  col;
        int  addr;
        bit  last;
        n_w = start_count(c.pad_l + c.w + c.pad_r - c.side, c.step);
        n_h = start_count(c.pad_t + c.h + c.pad_b - c.side, c.step);
        for (int sr = 0; sr < n_h; sr++) begin
            for (int sc = 0; sc < n_w; sc++) begin
                for (int wr = 0; wr < c.side; wr++) begin
                    for (int wc = 0; wc < c.side; wc++) begin
                        for (int dd = 0; dd < c.d; dd++) begin
                            row  = sr * c.step + wr;
                            col  = sc * c.step + wc;
                            last = (sr == n_h - 1) && (sc == n_w - 1) && (wr == c.side - 1)
                                && (wc == c.side - 1) && (dd == c.d - 1);
                            if (col < c.pad_l || col >= c.pad_l + c.w
                                || row < c.pad_t || row >= c.pad_t + c.h) begin
                                exp_data.push_back('0); // padding beat
                            end else begin
                                addr = (row - c.pad_t) * c.w * c.d + (col - c.pad_l) * c.d + dd;
                                exp_data.push_back({4{16'(addr)}});
                                exp_reads++;
                            end
                            exp_last.push_back(last);
                        end
                    end
                end
            end
        end
    endtask

    task automatic collect_beats(input string name);
        int n;
        n = exp_data.size();
        while (got_data.size() < n) begin
            @(posedge clk);
            #1;
        end
        for (int i = 0; i < n; i++) begin
            compare(got_data.pop_front(), exp_data.pop_front(),
                    $sformatf("%s beat %0d data", name, i));
            compare(64'(got_last.pop_front()), 64'(exp_last.pop_front()),
                    $sformatf("%s beat %0d last", name, i));
        end
        repeat (20) @(posedge clk);
        #1;
        compare(64'(got_data.size()), 64'd0, $sformatf("%s beats past the end", name));
        compare(64'(n_reads - reads_base), 64'(exp_reads), $sformatf("%s memory reads", name));
        reads_base = n_reads;
        exp_reads  = 0;
    endtask

    task automatic report_test(input string name, input int err_before);
        n_tests++;
        $display("test %s finished with %0d errors", name, n_errors - err_before);
    endtask

    task automatic check_reset();
        int err_before;
        err_before = n_errors;
        compare(64'(image_val), 64'd0, "image valid after reset");
        compare(64'(rd_val), 64'd0, "read valid after reset");
        for (int i = 0; i < 2 && !next_rdy; i++) begin
            @(posedge clk);
            #1;
        end
        compare(64'(next_rdy), 64'd1, "next ready within 2 cycles of reset");
        report_test("reset", err_before);
    endtask

    task automatic scan_and_check(input string name, input scan_cfg_t c);
        int err_before;
        err_before = n_errors;
        load_config(c);
        start_scan();
        build_expected(c);
        collect_beats(name);
        report_test(name, err_before);
    endtask

    // second config goes into the shadow registers while the first scan runs
    task automatic back_to_back();
        int err_before;
        err_before = n_errors;
        load_config(cfg_plain);
        start_scan();
        build_expected(cfg_plain);
        load_config(cfg_b);
        start_scan();
        build_expected(cfg_b);
        collect_beats("back to back");
        report_test("back to back", err_before);
    endtask

    initial begin
        cfg_data  = '0;
        cfg_addr  = '0;
        cfg_valid = 1'b0;
        next      = 1'b0;

        // w, h, d, pad l r t b, side, step
        cfg_plain  = '{4, 3, 2, 0, 0, 0, 0, 1, 1};
        cfg_pad    = '{4, 3, 2, 1, 1, 1, 1, 3, 1};
        cfg_stride = '{6, 5, 2, 2, 0, 1, 0, 2, 2};
        cfg_b      = '{3, 3, 1, 0, 1, 0, 1, 2, 1};

        cycle_limit = 4 * (2 * beat_count(cfg_plain) + 2 * beat_count(cfg_pad)
                    + beat_count(cfg_stride) + beat_count(cfg_b)) + 200;

        @(negedge rst);
        check_reset();
        scan_and_check("plain stream", cfg_plain);
        scan_and_check("padded window", cfg_pad);
        scan_and_check("stride with uneven padding", cfg_stride);
        random_rdy = 1'b1;
        scan_and_check("back-pressure", cfg_pad);
        random_rdy = 1'b0;
        back_to_back();

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- window_counter.sv
module window_counter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clear_i,
    input  logic                   carry_i,  // advance from the inner stage
    input  image_read_pkg::coord_t limit_i,
    input  image_read_pkg::coord_t step_i,
    output image_read_pkg::coord_t count_o,
    output logic                   carry_o,
    output logic                   done_o
);

    assign done_o  = (count_o >= limit_i);
    assign carry_o = carry_i & done_o; // wraps, so the outer stage moves

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            count_o <= '0;
        end else if (carry_i) begin
            if (done_o) begin
                count_o <= '0;
            end else begin
                count_o <= count_o + step_i;
            end
        end
    end

endmodule
